//--- compile.f
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_regfile.sv
rtl/lc4_fetch.sv
rtl/lc4_decode.sv
rtl/lc4_execute.sv
rtl/lc4_memory.sv
rtl/lc4_core.sv
dv/tb_clock_gen.sv
dv/tb_lc4_core.sv

//--- dv/tb_lc4_core.sv
module tb_lc4_core;

  localparam int period    = 100;
  localparam int max_insns = 64;
  localparam int rand_len  = 40;
  localparam int rand_runs = 4;
  // directed program lengths plus the random ones
  localparam int total_insns = 2 + 8 + 6 + 6 + 7 + rand_runs * rand_len;
  localparam int limit_cycles = total_insns * 20 + 200;

  typedef struct packed {
    logic [15:0] pc;
    logic [15:0] insn;
    logic        rf_we;
    logic [2:0]  wsel;
    logic [15:0] data;
    logic        nzp_we;
    logic [2:0]  nzp;
    logic        dm_we;
    logic [15:0] addr;
    logic [15:0] mdata;
  } trace_t;

  logic        gwe;
  logic        rst_n;
  logic        reset_req;
  logic [15:0] cur_insn;
  logic [15:0] cur_dmem_data;
  logic [15:0] cur_pc;
  logic [15:0] dmem_addr;
  logic        dmem_we;
  logic [15:0] dmem_towrite;
  logic [1:0]  t_stall;
  trace_t      act_trace;

  logic [15:0] prog [max_insns];
  logic [15:0] staged [$];
  int          prog_len;
  logic [15:0] dmem [65536];
  logic [15:0] ref_mem [65536];
  logic [15:0] ref_regs [8];
  trace_t      expected [max_insns];
  int          fetch_cyc [max_insns];
  int          got_cyc [max_insns];
  int          gap3 [max_insns];  // load-use bubbles seen just before each entry
  int          pre_bubbles;
  int          pre_bad;
  logic [31:0] lfsr = 32'h358d;
  string       test_name;
  int          test_errors;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          n_failed;

  tb_clock_gen #(.period(period)) clk_gen_i (
    .i_reset_req (reset_req),
    .o_gwe       (gwe),
    .o_rst_n     (rst_n)
  );

  lc4_core dut_i (
    .gwe                 (gwe),
    .i_rst_n             (rst_n),
    .i_cur_insn          (cur_insn),
    .i_cur_dmem_data     (cur_dmem_data),
    .o_cur_pc            (cur_pc),
    .o_dmem_addr         (dmem_addr),
    .o_dmem_we           (dmem_we),
    .o_dmem_towrite      (dmem_towrite),
    .o_test_stall        (t_stall),
    .o_test_cur_pc       (act_trace.pc),
    .o_test_cur_insn     (act_trace.insn),
    .o_test_regfile_we   (act_trace.rf_we),
    .o_test_regfile_wsel (act_trace.wsel),
    .o_test_regfile_data (act_trace.data),
    .o_test_nzp_we       (act_trace.nzp_we),
    .o_test_nzp_new_bits (act_trace.nzp),
    .o_test_dmem_we      (act_trace.dm_we),
    .o_test_dmem_addr    (act_trace.addr),
    .o_test_dmem_data    (act_trace.mdata)
  );

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
    logic [15:0] m;
    m = 16'hffff << bits;
    return v[bits-1] ? (v | m) : (v & ~m);
  endfunction

  function automatic logic [15:0] insn_rrr(input logic [3:0] op, input logic [2:0] d, s, sub, t);
    return {op, d, s, sub, t};
  endfunction

  function automatic logic [15:0] insn_ri(input logic [3:0] op, input logic [2:0] d, s,
                                          input logic [5:0] imm6);
    return {op, d, s, imm6};
  endfunction

  function automatic logic [15:0] insn_const(input logic [2:0] d, input logic [8:0] imm9);
    return {4'b1001, d, imm9};
  endfunction

  function automatic logic [15:0] fetch_word(input logic [15:0] pc);
    logic [15:0] idx;
    idx = pc - 16'h8200;
    if (idx < prog_len) return prog[idx];
    return 16'h0000;  // NOP past the program end
  endfunction

  // both memories answer on the falling edge, a store lands in its memory-stage cycle
  always @(negedge gwe) begin
    if (dmem_we === 1'b1) dmem[dmem_addr] = dmem_towrite;
    cur_insn      = fetch_word(cur_pc);
    cur_dmem_data = $isunknown(dmem_addr) ? 16'h0000 : dmem[dmem_addr];
  end

  task automatic check(input string what, input logic [15:0] exp_v, input logic [15:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      test_errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  // in-order model of the program, one trace entry per instruction
  task automatic run_reference();
    logic [15:0] w;
    logic [15:0] rs_v;
    logic [15:0] rt_v;
    logic [15:0] a;
    trace_t      e;
    for (int i = 0; i < 8; i++) ref_regs[i] = '0;
    for (int i = 0; i < prog_len; i++) begin
      w      = prog[i];
      e      = '0;
      e.pc   = 16'h8200 + 16'(i);
      e.insn = w;
      rs_v   = ref_regs[w[8:6]];
      rt_v   = ref_regs[w[2:0]];
      a      = rs_v + sext(w[5:0], 6);
      case (w[15:12])
        4'b0001: begin
          e.rf_we = 1'b1;
          if (w[5]) e.data = rs_v + sext(w[4:0], 5);
          else e.data = (w[5:3] == 3'b010) ? rs_v - rt_v : rs_v + rt_v;
        end
        4'b0101: {e.rf_we, e.data} = {1'b1, rs_v & rt_v};
        4'b0110: begin
          {e.rf_we, e.addr, e.data} = {1'b1, a, ref_mem[a]};
          e.mdata = e.data;
        end
        4'b0111: begin
          {e.dm_we, e.addr, e.mdata} = {1'b1, a, ref_regs[w[11:9]]};
          ref_mem[a] = e.mdata;
        end
        4'b1001: {e.rf_we, e.data} = {1'b1, sext(w[8:0], 9)};
        default: e.rf_we = 1'b0;
      endcase
      if (e.rf_we) begin
        e.wsel   = w[11:9];
        e.nzp_we = 1'b1;
        e.nzp    = e.data[15] ? 3'b100 : (e.data == 16'h0000) ? 3'b010 : 3'b001;
        ref_regs[e.wsel] = e.data;
      end
      expected[i] = e;
    end
  endtask

  task automatic compare_entry(input int i, input trace_t act);
    trace_t e;
    string  tag;
    e   = expected[i];
    tag = $sformatf("entry %0d", i);
    check({tag, " pc"}, e.pc, act.pc);
    check({tag, " insn"}, e.insn, act.insn);
    check({tag, " regfile_we"}, e.rf_we, act.rf_we);
    check({tag, " nzp_we"}, e.nzp_we, act.nzp_we);
    check({tag, " dmem_we"}, e.dm_we, act.dm_we);
    check({tag, " dmem_addr"}, e.addr, act.addr);
    check({tag, " dmem_data"}, e.mdata, act.mdata);
    if (e.rf_we) begin
      check({tag, " wsel"}, e.wsel, act.wsel);
      check({tag, " wdata"}, e.data, act.data);
      check({tag, " nzp"}, e.nzp, act.nzp);
    end
  endtask

  task automatic run_program(input string name);
    int          cyc;
    int          got;
    int          gap;
    logic [15:0] idx;
    logic        port_we;
    logic [15:0] port_addr;
    logic [15:0] port_data;
    test_name   = name;
    test_errors = 0;
    @(negedge gwe);
    reset_req = 1'b1;
    @(negedge gwe);  // pipeline already flushed by one reset edge
    prog_len = staged.size();
    foreach (staged[i]) prog[i] = staged[i];
    staged.delete();
    for (int a = 0; a < 65536; a++) begin
      dmem[a]    = {a[7:0], a[15:8]} ^ 16'h3c5a;
      ref_mem[a] = dmem[a];
    end
    for (int i = 0; i < max_insns; i++) fetch_cyc[i] = -1;
    run_reference();
    @(posedge rst_n);
    reset_req   = 1'b0;
    cyc         = 0;
    got         = 0;
    gap         = 0;
    pre_bubbles = 0;
    pre_bad     = 0;
    port_we     = 1'b0;
    port_addr   = '0;
    port_data   = '0;
    while (got < prog_len) begin
      idx = cur_pc - 16'h8200;
      if (idx < prog_len && fetch_cyc[idx] < 0) fetch_cyc[idx] = cyc;
      if (t_stall == 2'd0) begin
        compare_entry(got, act_trace);
        // memory port as seen one cycle before the entry reached the trace
        check("dmem port we", expected[got].dm_we, port_we);
        if (expected[got].dm_we) begin
          check("dmem port addr", expected[got].addr, port_addr);
          check("dmem port data", expected[got].mdata, port_data);
        end
        got_cyc[got] = cyc;
        gap3[got]    = gap;
        gap          = 0;
        got++;
      end else begin
        check("dmem port we in bubble", 16'd0, port_we);
        if (t_stall == 2'd3) gap++;
        if (got == 0) begin
          pre_bubbles++;
          if (t_stall != 2'd2 || act_trace.rf_we || act_trace.nzp_we || act_trace.dm_we) pre_bad = 1;
        end
      end
      port_we   = dmem_we;
      port_addr = dmem_addr;
      port_data = dmem_towrite;
      if (got < prog_len) begin
        @(negedge gwe);
        cyc++;
      end
    end
    for (int i = 0; i < prog_len; i++) begin
      if (expected[i].dm_we) check("stored word", ref_mem[expected[i].addr],
                                   dmem[expected[i].addr]);
    end
  endtask

  task automatic report_test();
    n_tests++;
    if (test_errors != 0) n_failed++;
    $display("%-12s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed", test_errors);
  endtask

  task automatic test_reset();
    staged.push_back(insn_const(3'd1, 9'h07b));
    staged.push_back(insn_const(3'd2, 9'h100));
    run_program("reset");
    check("bubbles before first entry", 16'd4, 16'(pre_bubbles));
    check("bubble not clean", 16'd0, 16'(pre_bad));  // stall 2 and no write enables
    report_test();
  endtask

  task automatic test_alu_bypass();
    staged.push_back(insn_const(3'd1, 9'd5));
    staged.push_back(insn_const(3'd2, 9'h1fd));                   // -3
    staged.push_back(insn_rrr(4'b0001, 3'd3, 3'd1, 3'b000, 3'd2));
    staged.push_back(insn_rrr(4'b0001, 3'd4, 3'd3, 3'b010, 3'd1)); // sub
    staged.push_back(insn_rrr(4'b0101, 3'd5, 3'd4, 3'b000, 3'd3)); // and
    staged.push_back(insn_ri(4'b0001, 3'd6, 3'd5, 6'b111001));     // add imm -7
    staged.push_back(insn_rrr(4'b0001, 3'd7, 3'd6, 3'b000, 3'd6));
    staged.push_back(insn_rrr(4'b0001, 3'd0, 3'd7, 3'b010, 3'd7));
    run_program("alu_bypass");
    check("latency of entry 3", 16'd4, 16'(got_cyc[3] - fetch_cyc[3]));
    report_test();
  endtask

  task automatic test_load_use();
    staged.push_back(insn_const(3'd1, 9'h020));
    staged.push_back(insn_const(3'd2, 9'd9));
    staged.push_back(insn_ri(4'b0110, 3'd3, 3'd1, 6'd3));
    staged.push_back(insn_rrr(4'b0001, 3'd4, 3'd3, 3'b000, 3'd2));
    staged.push_back(insn_ri(4'b0110, 3'd5, 3'd1, 6'h3e));
    staged.push_back(insn_ri(4'b0111, 3'd5, 3'd1, 6'd4));  // store data is the load
    run_program("load_use");
    check("bubbles before add", 16'd1, 16'(gap3[3]));
    check("bubbles before store", 16'd1, 16'(gap3[5]));
    check("bubbles before load", 16'd0, 16'(gap3[2]));
    report_test();
  endtask

  task automatic test_store_load();
    staged.push_back(insn_const(3'd1, 9'h040));
    staged.push_back(insn_const(3'd2, 9'h19c));  // -100
    staged.push_back(insn_ri(4'b0111, 3'd2, 3'd1, 6'd5));
    staged.push_back(insn_const(3'd2, 9'h000));
    staged.push_back(insn_ri(4'b0110, 3'd3, 3'd1, 6'd5));
    staged.push_back(insn_rrr(4'b0001, 3'd4, 3'd3, 3'b000, 3'd3));
    run_program("store_load");
    check("word at 0045", 16'hff9c, dmem[16'h0045]);
    report_test();
  endtask

  task automatic test_nzp();
    staged.push_back(insn_const(3'd1, 9'h1ff));
    staged.push_back(insn_const(3'd2, 9'h000));
    staged.push_back(insn_const(3'd3, 9'd7));
    staged.push_back(insn_rrr(4'b0001, 3'd4, 3'd1, 3'b000, 3'd1));
    staged.push_back(insn_ri(4'b0111, 3'd3, 3'd2, 6'd0));
    staged.push_back(16'h0000);
    staged.push_back(insn_ri(4'b0001, 3'd5, 3'd2, 6'b100000));
    run_program("nzp");
    report_test();
  endtask

  task automatic test_random(input int run);
    logic [2:0] kind;
    logic [2:0] d;
    logic [2:0] s;
    logic [2:0] t;
    for (int i = 0; i < rand_len; i++) begin
      kind = 3'(rand_bits(3));
      d    = 3'(rand_bits(3));
      s    = 3'(rand_bits(3));
      t    = 3'(rand_bits(3));
      case (kind)
        3'd0: staged.push_back(insn_rrr(4'b0001, d, s, 3'b000, t));
        3'd1: staged.push_back(insn_rrr(4'b0001, d, s, 3'b010, t));
        3'd2: staged.push_back(insn_rrr(4'b0101, d, s, 3'b000, t));
        3'd3: staged.push_back(insn_ri(4'b0001, d, s, {1'b1, 5'(rand_bits(5))}));
        3'd4: staged.push_back(insn_const(d, 9'(rand_bits(9))));
        3'd6: staged.push_back(insn_ri(4'b0111, d, s, 6'(rand_bits(6))));
        default: staged.push_back(insn_ri(4'b0110, d, s, 6'(rand_bits(6))));  // loads twice as often
      endcase
    end
    run_program($sformatf("random_%0d", run));
    report_test();
  endtask

  initial begin
    #(limit_cycles * period);
    $display("timeout: run still busy after %0d cycles", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    cur_insn      = 16'h0000;
    cur_dmem_data = 16'h0000;
    reset_req     = 1'b0;
    prog_len      = 0;
    @(posedge rst_n);
    test_reset();
    test_alu_bypass();
    test_load_use();
    test_store_load();
    test_nzp();
    for (int r = 0; r < rand_runs; r++) test_random(r);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int period = 100
) (
  input  logic i_reset_req,
  output logic o_gwe,
  output logic o_rst_n
);

  initial begin
    o_gwe = 1'b0;
    forever #(period / 2) o_gwe = ~o_gwe;
  end

  // reset spans three rising edges and lets go on a falling edge
  initial begin
    o_rst_n = 1'b0;
    forever begin
      repeat (3) @(posedge o_gwe);
      @(negedge o_gwe);
      o_rst_n = 1'b1;
      @(posedge i_reset_req);  // asserted again on request
      o_rst_n = 1'b0;
    end
  end

endmodule

//--- rtl/lc4_core.sv
module lc4_core (
  input  logic        gwe,
  input  logic        i_rst_n,
  input  logic [15:0] i_cur_insn,
  input  logic [15:0] i_cur_dmem_data,
  output logic [15:0] o_cur_pc,
  output logic [15:0] o_dmem_addr,
  output logic        o_dmem_we,
  output logic [15:0] o_dmem_towrite,
  output logic [1:0]  o_test_stall,  // 0 normal, 2 reset bubble, 3 load-use
  output logic [15:0] o_test_cur_pc,
  output logic [15:0] o_test_cur_insn,
  output logic        o_test_regfile_we,
  output logic [2:0]  o_test_regfile_wsel,
  output logic [15:0] o_test_regfile_data,
  output logic        o_test_nzp_we,
  output logic [2:0]  o_test_nzp_new_bits,
  output logic        o_test_dmem_we,
  output logic [15:0] o_test_dmem_addr,
  output logic [15:0] o_test_dmem_data
);
  import lc4_pipe_pkg::*;

  logic [15:0] fd_pc;
  logic [15:0] fd_insn;
  logic        fd_valid;
  logic        stall;
  dx_t         dx;
  xm_t         xm;
  mw_t         mw;
  wb_t         wb;

  lc4_fetch fetch_i (
    .gwe        (gwe),
    .i_rst_n    (i_rst_n),
    .i_stall    (stall),
    .i_cur_insn (i_cur_insn),
    .o_cur_pc   (o_cur_pc),
    .o_fd_pc    (fd_pc),
    .o_fd_insn  (fd_insn),
    .o_fd_valid (fd_valid)
  );

  lc4_decode decode_i (
    .gwe        (gwe),
    .i_rst_n    (i_rst_n),
    .i_fd_pc    (fd_pc),
    .i_fd_insn  (fd_insn),
    .i_fd_valid (fd_valid),
    .i_wb       (wb),
    .o_stall    (stall),
    .o_dx       (dx)
  );

  lc4_execute execute_i (
    .gwe     (gwe),
    .i_rst_n (i_rst_n),
    .i_dx    (dx),
    .i_wb    (wb),
    .o_xm    (xm)
  );

  lc4_memory memory_i (
    .gwe             (gwe),
    .i_rst_n         (i_rst_n),
    .i_xm            (xm),
    .i_cur_dmem_data (i_cur_dmem_data),
    .o_dmem_addr     (o_dmem_addr),
    .o_dmem_we       (o_dmem_we),
    .o_dmem_towrite  (o_dmem_towrite),
    .o_mw            (mw)
  );

  // writeback bus feeds the regfile and the execute bypass
  assign wb.we   = mw.ctrl.regfile_we;
  assign wb.wsel = mw.ctrl.rd;
  assign wb.data = mw.wdata;

  assign o_test_stall        = mw.stall;
  assign o_test_cur_pc       = mw.pc;
  assign o_test_cur_insn     = mw.insn;
  assign o_test_regfile_we   = wb.we;
  assign o_test_regfile_wsel = wb.wsel;
  assign o_test_regfile_data = wb.data;
  assign o_test_nzp_we       = wb.we;  // every register write sets nzp
  assign o_test_nzp_new_bits = mw.nzp;
  assign o_test_dmem_we      = mw.dmem_we;
  assign o_test_dmem_addr    = mw.dmem_addr;
  assign o_test_dmem_data    = mw.dmem_data;

endmodule

//--- rtl/lc4_memory.sv
module lc4_memory (
  input  logic               gwe,
  input  logic               i_rst_n,
  input  lc4_pipe_pkg::xm_t  i_xm,
  input  logic [15:0]        i_cur_dmem_data,
  output logic [15:0]        o_dmem_addr,
  output logic               o_dmem_we,
  output logic [15:0]        o_dmem_towrite,
  output lc4_pipe_pkg::mw_t  o_mw
);
  import lc4_pipe_pkg::*;

  logic        is_mem;
  logic [15:0] wdata;
  logic [15:0] dmem_data;
  logic [2:0]  nzp;

  assign is_mem         = i_xm.ctrl.is_load || i_xm.ctrl.is_store;
  assign o_dmem_addr    = is_mem ? i_xm.alu_result : 16'h0000;
  assign o_dmem_we      = i_xm.ctrl.is_store;
  assign o_dmem_towrite = i_xm.ctrl.is_store ? i_xm.store_data : 16'h0000;

  assign wdata = i_xm.ctrl.is_load ? i_cur_dmem_data : i_xm.alu_result;

  // value read or written, for the trace
  assign dmem_data = i_xm.ctrl.is_load  ? i_cur_dmem_data :
                     i_xm.ctrl.is_store ? i_xm.store_data : 16'h0000;

  assign nzp[2] = wdata[15];
  assign nzp[1] = (wdata == 16'h0000);
  assign nzp[0] = !wdata[15] && (wdata != 16'h0000);

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_mw       <= '0;
      o_mw.stall <= stall_bubble;
    end else begin
      o_mw.pc        <= i_xm.pc;
      o_mw.insn      <= i_xm.insn;
      o_mw.ctrl      <= i_xm.ctrl;
      o_mw.wdata     <= wdata;
      o_mw.dmem_addr <= o_dmem_addr;
      o_mw.dmem_data <= dmem_data;
      o_mw.dmem_we   <= o_dmem_we;
      o_mw.nzp       <= nzp;
      o_mw.stall     <= i_xm.stall;
    end
  end

endmodule

//--- rtl/lc4_execute.sv
module lc4_execute (
  input  logic               gwe,
  input  logic               i_rst_n,
  input  lc4_pipe_pkg::dx_t  i_dx,
  input  lc4_pipe_pkg::wb_t  i_wb,
  output lc4_pipe_pkg::xm_t  o_xm
);
  import lc4_pipe_pkg::*;
  import lc4_isa_pkg::*;

  insn_u             iw;
  logic [word_w-1:0] op_a;
  logic [word_w-1:0] op_b;
  logic [word_w-1:0] result;

  // nearest producer wins, memory stage before writeback
  function automatic logic [word_w-1:0] bypass(input logic [reg_sel_w-1:0] sel,
                                               input logic [word_w-1:0]    rf_val,
                                               input xm_t                  xm,
                                               input wb_t                  wb);
    if (xm.ctrl.regfile_we && xm.ctrl.rd == sel) begin
      return xm.alu_result;
    end else if (wb.we && wb.wsel == sel) begin
      return wb.data;
    end
    return rf_val;
  endfunction

  assign iw   = i_dx.insn;
  assign op_a = bypass(i_dx.ctrl.rs, i_dx.rs_data, o_xm, i_wb);
  assign op_b = bypass(i_dx.ctrl.rt, i_dx.rt_data, o_xm, i_wb);

  always_comb begin
    if (i_dx.ctrl.is_const) begin
      result = {{(word_w-9){iw.const_v.imm9[8]}}, iw.const_v.imm9};
    end else if (i_dx.ctrl.is_load || i_dx.ctrl.is_store) begin
      result = op_a + {{(word_w-6){iw.imm_v.imm6[5]}}, iw.imm_v.imm6};  // effective address
    end else if (i_dx.ctrl.is_alu_imm) begin
      result = op_a + {{(word_w-5){iw.imm_v.imm6[4]}}, iw.imm_v.imm6[4:0]};
    end else if (iw.reg_v.opcode == op_logic) begin
      result = op_a & op_b;
    end else if (iw.reg_v.subop == sub_sub) begin
      result = op_a - op_b;
    end else begin
      result = op_a + op_b;
    end
  end

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_xm       <= '0;
      o_xm.stall <= stall_bubble;
    end else begin
      o_xm.pc         <= i_dx.pc;
      o_xm.insn       <= i_dx.insn;
      o_xm.ctrl       <= i_dx.ctrl;
      o_xm.alu_result <= result;
      o_xm.store_data <= op_b;  // rt already bypassed
      o_xm.stall      <= i_dx.stall;
    end
  end

endmodule

//--- rtl/lc4_decode.sv
module lc4_decode (
  input  logic               gwe,
  input  logic               i_rst_n,
  input  logic [15:0]        i_fd_pc,
  input  logic [15:0]        i_fd_insn,
  input  logic               i_fd_valid,
  input  lc4_pipe_pkg::wb_t  i_wb,
  output logic               o_stall,
  output lc4_pipe_pkg::dx_t  o_dx
);
  import lc4_pipe_pkg::*;
  import lc4_isa_pkg::*;

  insn_u             iw;
  ctrl_t             ctrl;
  logic [word_w-1:0] rs_data;
  logic [word_w-1:0] rt_data;

  assign iw = i_fd_insn;

  always_comb begin
    ctrl    = '0;
    ctrl.rd = iw.reg_v.rd;
    ctrl.rs = iw.reg_v.rs;
    ctrl.rt = iw.reg_v.rt;
    unique case (iw.reg_v.opcode)
      op_nop_br: ctrl.is_valid = (iw.reg_v.rd == '0);  // only NOP, no branches
      op_arith: begin
        if (iw.imm_v.imm6[5]) begin
          {ctrl.is_alu_imm, ctrl.rs_re, ctrl.regfile_we, ctrl.is_valid} = '1;
        end else if (iw.reg_v.subop == sub_add || iw.reg_v.subop == sub_sub) begin
          {ctrl.rs_re, ctrl.rt_re, ctrl.regfile_we, ctrl.is_valid} = '1;
        end
      end
      op_logic: begin
        if (!iw.imm_v.imm6[5] && iw.reg_v.subop == sub_and) begin
          {ctrl.rs_re, ctrl.rt_re, ctrl.regfile_we, ctrl.is_valid} = '1;
        end
      end
      op_ldr:   {ctrl.rs_re, ctrl.regfile_we, ctrl.is_load, ctrl.is_valid} = '1;
      op_str: begin
        ctrl.rt = iw.reg_v.rd;  // store data register sits in the rd field
        {ctrl.rs_re, ctrl.rt_re, ctrl.is_store, ctrl.is_valid} = '1;
      end
      op_const: {ctrl.regfile_we, ctrl.is_const, ctrl.is_valid} = '1;
      default:  ctrl.is_valid = 1'b0;
    endcase
    if (!i_fd_valid || !ctrl.is_valid) begin
      ctrl = '0;  // unsupported words pass as no-ops
    end
  end

  lc4_regfile regfile_i (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs_sel  (ctrl.rs),
    .i_rt_sel  (ctrl.rt),
    .i_wb      (i_wb),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  // load now in execute whose result a source here needs, store data included
  assign o_stall = o_dx.ctrl.is_valid && o_dx.ctrl.is_load &&
                   ((ctrl.rs_re && ctrl.rs == o_dx.ctrl.rd) ||
                    (ctrl.rt_re && ctrl.rt == o_dx.ctrl.rd));

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_dx       <= '0;
      o_dx.stall <= stall_bubble;
    end else if (o_stall) begin
      o_dx       <= '0;  // bubble into execute
      o_dx.stall <= stall_load_use;
    end else begin
      o_dx.pc      <= i_fd_pc;
      o_dx.insn    <= i_fd_insn;
      o_dx.ctrl    <= ctrl;
      o_dx.rs_data <= rs_data;
      o_dx.rt_data <= rt_data;
      o_dx.stall   <= i_fd_valid ? stall_none : stall_bubble;
    end
  end

endmodule

//--- rtl/lc4_fetch.sv
module lc4_fetch (
  input  logic        gwe,
  input  logic        i_rst_n,
  input  logic        i_stall,
  input  logic [15:0] i_cur_insn,
  output logic [15:0] o_cur_pc,
  output logic [15:0] o_fd_pc,
  output logic [15:0] o_fd_insn,
  output logic        o_fd_valid
);
  import lc4_pipe_pkg::*;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_cur_pc <= reset_pc;
    end else if (!i_stall) begin
      o_cur_pc <= o_cur_pc + 16'd1;  // no branches, so always sequential
    end
  end

  // fetched word waits here for decode, held through a load-use stall
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_fd_pc    <= '0;
      o_fd_insn  <= '0;
      o_fd_valid <= 1'b0;
    end else if (!i_stall) begin
      o_fd_pc    <= o_cur_pc;
      o_fd_insn  <= i_cur_insn;
      o_fd_valid <= 1'b1;
    end
  end

endmodule

//--- rtl/lc4_regfile.sv
module lc4_regfile (
  input  logic               gwe,
  input  logic               i_rst_n,
  input  logic [2:0]         i_rs_sel,
  input  logic [2:0]         i_rt_sel,
  input  lc4_pipe_pkg::wb_t  i_wb,
  output logic [15:0]        o_rs_data,
  output logic [15:0]        o_rt_data
);

  logic [15:0] regs [8];

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.we) begin
      regs[i_wb.wsel] <= i_wb.data;
    end
  end

  // writeback in the same cycle is visible to decode
  assign o_rs_data = (i_wb.we && i_wb.wsel == i_rs_sel) ? i_wb.data : regs[i_rs_sel];
  assign o_rt_data = (i_wb.we && i_wb.wsel == i_rt_sel) ? i_wb.data : regs[i_rt_sel];

endmodule

//--- rtl/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

  localparam logic [lc4_isa_pkg::word_w-1:0] reset_pc = 16'h8200;

  // trace stall codes
  localparam logic [1:0] stall_none     = 2'd0;
  localparam logic [1:0] stall_bubble   = 2'd2;  // reset bubble
  localparam logic [1:0] stall_load_use = 2'd3;

  typedef struct packed {
    logic [lc4_isa_pkg::reg_sel_w-1:0] rs;
    logic [lc4_isa_pkg::reg_sel_w-1:0] rt;
    logic [lc4_isa_pkg::reg_sel_w-1:0] rd;
    logic rs_re;
    logic rt_re;
    logic regfile_we;
    logic is_load;
    logic is_store;
    logic is_alu_imm;
    logic is_const;
    logic is_valid;
  } ctrl_t;

  typedef struct packed {
    logic [lc4_isa_pkg::word_w-1:0] pc;
    logic [lc4_isa_pkg::word_w-1:0] insn;
    ctrl_t                          ctrl;
    logic [lc4_isa_pkg::word_w-1:0] rs_data;
    logic [lc4_isa_pkg::word_w-1:0] rt_data;
    logic [1:0]                     stall;
  } dx_t;

  typedef struct packed {
    logic [lc4_isa_pkg::word_w-1:0] pc;
    logic [lc4_isa_pkg::word_w-1:0] insn;
    ctrl_t                          ctrl;
    logic [lc4_isa_pkg::word_w-1:0] alu_result;  // address for loads and stores
    logic [lc4_isa_pkg::word_w-1:0] store_data;
    logic [1:0]                     stall;
  } xm_t;

  typedef struct packed {
    logic [lc4_isa_pkg::word_w-1:0] pc;
    logic [lc4_isa_pkg::word_w-1:0] insn;
    ctrl_t                          ctrl;
    logic [lc4_isa_pkg::word_w-1:0] wdata;
    logic [lc4_isa_pkg::word_w-1:0] dmem_addr;
    logic [lc4_isa_pkg::word_w-1:0] dmem_data;
    logic                           dmem_we;
    logic [2:0]                     nzp;
    logic [1:0]                     stall;
  } mw_t;

  typedef struct packed {
    logic                              we;
    logic [lc4_isa_pkg::reg_sel_w-1:0] wsel;
    logic [lc4_isa_pkg::word_w-1:0]    data;
  } wb_t;

endpackage

//--- rtl/lc4_isa_pkg.sv
package lc4_isa_pkg;

  localparam int word_w    = 16;
  localparam int reg_sel_w = 3;

  // primary opcodes, insn[15:12]
  localparam logic [3:0] op_nop_br = 4'b0000;
  localparam logic [3:0] op_arith  = 4'b0001;
  localparam logic [3:0] op_logic  = 4'b0101;
  localparam logic [3:0] op_ldr    = 4'b0110;
  localparam logic [3:0] op_str    = 4'b0111;
  localparam logic [3:0] op_const  = 4'b1001;

  // secondary opcodes of the register forms, insn[5:3]
  localparam logic [2:0] sub_add = 3'b000;
  localparam logic [2:0] sub_sub = 3'b010;
  localparam logic [2:0] sub_and = 3'b000;  // under op_logic

  typedef struct packed {
    logic [3:0]           opcode;
    logic [reg_sel_w-1:0] rd;
    logic [reg_sel_w-1:0] rs;
    logic [2:0]           subop;
    logic [reg_sel_w-1:0] rt;
  } insn_reg_t;

  typedef struct packed {
    logic [3:0]           opcode;
    logic [reg_sel_w-1:0] rd;
    logic [reg_sel_w-1:0] rs;
    logic [5:0]           imm6;  // bit 5 set marks ADD imm, [4:0] is imm5
  } insn_imm_t;

  typedef struct packed {
    logic [3:0]           opcode;
    logic [reg_sel_w-1:0] rd;
    logic [8:0]           imm9;
  } insn_const_t;

  typedef union packed {
    insn_reg_t   reg_v;
    insn_imm_t   imm_v;
    insn_const_t const_v;
  } insn_u;

endpackage
